/* bench/golden_program.txt */
# P word_addr instr | W reg value (trace order) | H halt_pc, all hex
# Instr fields: op[15:12] rd[11:8] rs[7:4] rt/off[3:0], or op rd imm8
P 00 4105
P 01 42FD
P 02 0312
P 03 1431
P 04 2543
P 05 3652
P 06 407F
P 07 0701
P 08 4812
P 09 6683
P 0A 5983
P 0B 0A91
P 0C 4B00
P 0D 7B02
P 0E 4C11
P 0F 4C22
P 10 0CA7
P 11 7C01
P 12 4D40
P 13 5E83
P 14 7E01
P 15 3FEE
P 16 7F01
P 17 4166
P 18 01FD
P 19 F000
P 1A 4255
W 1 0005
W 2 FFFD
W 3 0002
W 4 FFFD
W 5 0000
W 6 FFFD
W 7 0005
W 8 0012
W 9 FFFD
W A 0002
W B 0000
W C 0007
W D 0040
W E FFFD
W F 0000
W 1 0040
H 0034

/* sources.f */
+incdir+design
design/isa_pkg.sv
design/hazard_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/hazard_forward.sv
design/cpu.sv
bench/cpu_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sources.f) design/cpu_config.svh

all: run

obj_dir/Vcpu_tb: sources.f $(SRCS)
	verilator --binary --assert -f sources.f --top-module cpu_tb -o Vcpu_tb

run: obj_dir/Vcpu_tb bench/golden_program.txt
	./obj_dir/Vcpu_tb

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* bench/cpu_tb.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu_tb;
    import isa_pkg::*;

    localparam int IA_W = $clog2(`IMEM_DEPTH);

    logic            clk;
    logic            arst_n;
    logic            prog_we;
    logic [IA_W-1:0] prog_addr;
    data_t           prog_data;
    logic            hlt;
    data_t           pc;
    logic            wb_valid;
    reg_idx_t        wb_reg;
    data_t           wb_data;

    logic [IA_W-1:0] prog_addrs [$];    // Program image from golden file
    data_t           prog_words [$];
    reg_idx_t        exp_regs [$];      // Expected trace in program order
    data_t           exp_vals [$];
    data_t           exp_halt_pc;
    bit              have_halt = 1'b0;
    int              wb_idx = 0;        // Next trace entry to match
    int              cycles = 0;
    int              cycle_limit = 0;

    cpu cpu_inst (
        .clk, .arst_n, .prog_we, .prog_addr, .prog_data,
        .hlt, .pc, .wb_valid, .wb_reg, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_wb(input string name, input reg_idx_t exp_reg, input data_t exp_data,
                            input reg_idx_t act_reg, input data_t act_data);
        if (act_reg !== exp_reg || act_data !== exp_data) begin
            $display("error: %s expected r%0d = %h, actual r%0d = %h",
                     name, exp_reg, exp_data, act_reg, act_data);
            stop_with_failure();
        end
    endtask

    task automatic check_halt(input string name, input data_t exp_pc, input data_t act_pc,
                              input int exp_n, input int act_n);
        if (act_pc !== exp_pc) begin
            $display("error: %s expected pc %h, actual pc %h", name, exp_pc, act_pc);
            stop_with_failure();
        end else if (act_n != exp_n) begin
            $display("error: %s expected %0d register writes, actual %0d", name, exp_n, act_n);
            stop_with_failure();
        end
    endtask

    // Golden line kinds P addr word, W reg value, H pc and # comment
    task automatic read_golden();
        int                fd;
        int                code;
        byte               kind;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [8*100-1:0]  rest;
        fd = $fopen("bench/golden_program.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/golden_program.txt");
            stop_with_failure();
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": code = $fgets(rest, fd);
                    "P": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        prog_addrs.push_back(a[IA_W-1:0]);
                        prog_words.push_back(data_t'(b));
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        exp_regs.push_back(reg_idx_t'(a));
                        exp_vals.push_back(data_t'(b));
                    end
                    "H": begin
                        code = $fscanf(fd, "%h", a);
                        exp_halt_pc = data_t'(a);
                        have_halt   = 1'b1;
                    end
                    default: begin
                        $display("Golden file has a line of unknown kind '%c'", kind);
                        stop_with_failure();
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_golden();
        if (!have_halt || prog_words.size() == 0) begin
            $display("Golden file lacks a program or a halt PC");
            stop_with_failure();
        end
        cycle_limit = 4 * prog_words.size() + 40;   // Generous bound on run length
        for (int i = 0; i < prog_words.size(); i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;                  // One word per cycle with core in reset
            prog_addr <= prog_addrs[i];
            prog_data <= prog_words[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (3) @(posedge clk);              // Reset cycles after the load
        arst_n <= 1'b1;

        while (!hlt) begin
            @(negedge clk);
        end
        check_halt("halt", exp_halt_pc, pc, exp_regs.size(), wb_idx);
        repeat (4) @(negedge clk);              // Core must stay frozen
        if (!hlt) begin
            $display("hlt dropped after it was raised");
            stop_with_failure();
        end else begin
            check_halt("halt hold", exp_halt_pc, pc, exp_regs.size(), wb_idx);
            $display("All tests passed!");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Trace monitor and timeout
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            if (wb_idx >= exp_regs.size()) begin
                $display("Unexpected register write r%0d = %h after the last trace entry",
                         wb_reg, wb_data);
                stop_with_failure();
            end else begin
                check_wb($sformatf("writeback %0d", wb_idx), exp_regs[wb_idx],
                         exp_vals[wb_idx], wb_reg, wb_data);
                wb_idx = wb_idx + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles = cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("Timeout: hlt not raised within %0d cycles", cycle_limit);
                stop_with_failure();
            end
        end
    end

endmodule

/* design/cpu.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module cpu (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           prog_we,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] prog_addr,
    input  isa_pkg::data_t                 prog_data,
    output logic                           hlt,
    output isa_pkg::data_t                 pc,
    output logic                           wb_valid,
    output isa_pkg::reg_idx_t              wb_reg,
    output isa_pkg::data_t                 wb_data
);
    import isa_pkg::*;
    import hazard_pkg::*;

    logic     stall_fd;               // From hazard unit
    logic     flush;                  // Taken branch in decode
    logic     halt_seen;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    br_fwd_e  fwd_br;
    data_t    fd_instr;
    data_t    fd_pc_plus2;
    data_t    branch_target;
    reg_idx_t rs_d;
    reg_idx_t rt_d;
    logic     is_branch_d;
    logic     is_store_d;
    opcode_e  dx_op;
    reg_idx_t dx_rd;
    reg_idx_t dx_rs;
    reg_idx_t dx_rt;
    data_t    dx_a;
    data_t    dx_b;
    data_t    dx_imm;
    logic     dx_we;
    logic     dx_load;
    logic     dx_halt;
    data_t    xm_result;
    data_t    xm_store_data;
    data_t    mem_alu_result;         // Memory stage forward
    reg_idx_t xm_rd;
    logic     xm_we;
    logic     xm_load;
    logic     xm_store;
    logic     xm_halt;

    fetch fetch (
        .clk, .arst_n, .stall_fd, .flush, .halt_seen, .branch_target,
        .prog_we, .prog_addr, .prog_data, .pc, .fd_instr, .fd_pc_plus2
    );

    decode decode (
        .clk, .arst_n, .fd_instr, .fd_pc_plus2, .stall_fd, .fwd_br, .mem_alu_result,
        .wb_valid, .wb_reg, .wb_data, .flush, .branch_target, .halt_seen,
        .rs_d, .rt_d, .is_branch_d, .is_store_d,
        .dx_op, .dx_rd, .dx_rs, .dx_rt, .dx_a, .dx_b, .dx_imm, .dx_we, .dx_load, .dx_halt
    );

    execute execute (
        .clk, .arst_n, .dx_op, .dx_rd, .dx_a, .dx_b, .dx_imm, .dx_we, .dx_load, .dx_halt,
        .fwd_a, .fwd_b, .mem_alu_result, .wb_data,
        .xm_result, .xm_store_data, .xm_rd, .xm_we, .xm_load, .xm_store, .xm_halt
    );

    memory memory (
        .clk, .arst_n, .xm_result, .xm_store_data, .xm_rd, .xm_we, .xm_load, .xm_store,
        .xm_halt, .mem_alu_result, .wb_valid, .wb_reg, .wb_data, .hlt
    );

    hazard_forward hazard (
        .rs_d, .rt_d, .is_branch_d, .is_store_d, .dx_rd, .dx_rs, .dx_rt, .dx_we, .dx_load,
        .xm_rd, .xm_we, .xm_load, .wb_valid, .wb_reg, .stall_fd, .fwd_a, .fwd_b, .fwd_br
    );

endmodule

/* design/hazard_forward.sv */
`timescale 1ns/100ps

module hazard_forward (
    input  isa_pkg::reg_idx_t    rs_d,
    input  isa_pkg::reg_idx_t    rt_d,
    input  logic                 is_branch_d,
    input  logic                 is_store_d,
    input  isa_pkg::reg_idx_t    dx_rd,
    input  isa_pkg::reg_idx_t    dx_rs,
    input  isa_pkg::reg_idx_t    dx_rt,
    input  logic                 dx_we,
    input  logic                 dx_load,
    input  isa_pkg::reg_idx_t    xm_rd,
    input  logic                 xm_we,
    input  logic                 xm_load,
    input  logic                 wb_valid,
    input  isa_pkg::reg_idx_t    wb_reg,
    output logic                 stall_fd,
    output hazard_pkg::fwd_sel_e fwd_a,
    output hazard_pkg::fwd_sel_e fwd_b,
    output hazard_pkg::br_fwd_e  fwd_br
);
    import isa_pkg::*;
    import hazard_pkg::*;

    logic ld_use;
    logic br_wait;

    // Producer match that never counts r0
    function automatic logic hit(logic we, reg_idx_t dst, reg_idx_t src);
        return we && (src != '0) && (dst == src);
    endfunction

    // Memory stage wins over writeback
    function automatic fwd_sel_e pick(reg_idx_t src, logic m_we, reg_idx_t m_rd,
                                      logic w_we, reg_idx_t w_rd);
        if (hit(m_we, m_rd, src)) begin
            return FWD_MEM;
        end
        return hit(w_we, w_rd, src) ? FWD_WB : FWD_REG;
    endfunction

    assign ld_use   = dx_load && (hit(dx_we, dx_rd, rs_d) || hit(dx_we, dx_rd, rt_d));
    assign br_wait  = is_branch_d &&
                      (hit(dx_we, dx_rd, rs_d) || hit(xm_we && xm_load, xm_rd, rs_d));
    assign stall_fd = ld_use || br_wait;

    assign fwd_br = (is_branch_d && hit(xm_we && !xm_load, xm_rd, rs_d)) ? BR_MEM : BR_REG;
    assign fwd_a  = pick(dx_rs, xm_we, xm_rd, wb_valid, wb_reg);
    assign fwd_b  = pick(dx_rt, xm_we, xm_rd, wb_valid, wb_reg);

    always_comb begin
        // Load data is not ready until writeback
        assert final (!(fwd_a == FWD_MEM && xm_load))
            else $error("Operand A forwarded from a load in memory stage");
    end

endmodule

/* design/memory.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module memory (
    input  logic              clk,
    input  logic              arst_n,
    input  isa_pkg::data_t    xm_result,
    input  isa_pkg::data_t    xm_store_data,
    input  isa_pkg::reg_idx_t xm_rd,
    input  logic              xm_we,
    input  logic              xm_load,
    input  logic              xm_store,
    input  logic              xm_halt,
    output isa_pkg::data_t    mem_alu_result,
    output logic              wb_valid,
    output isa_pkg::reg_idx_t wb_reg,
    output isa_pkg::data_t    wb_data,
    output logic              hlt
);
    import isa_pkg::*;

    localparam int DA_W = $clog2(`DMEM_DEPTH);

    data_t           dmem [`DMEM_DEPTH];
    logic [DA_W-1:0] addr;
    data_t           rd_data;

    assign addr           = xm_result[DA_W-1:0];   // Word address
    assign rd_data        = dmem[addr];            // Single cycle read
    assign mem_alu_result = xm_result;             // Forward to decode and execute

    always_ff @(posedge clk) begin
        if (xm_store) begin
            dmem[addr] <= xm_store_data;
        end
    end

    // MW register and trace outputs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_reg   <= '0;
            hlt      <= 1'b0;
        end else begin
            wb_valid <= xm_we;                     // r0 writes already dropped
            wb_reg   <= xm_rd;
            if (xm_halt) begin
                hlt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_data <= xm_load ? rd_data : xm_result;
    end

    // Nothing younger than HLT reaches writeback
    assert property (@(posedge clk) disable iff (!arst_n) hlt |-> !wb_valid)
        else $error("Register write after halt");

endmodule

/* design/execute.sv */
`timescale 1ns/100ps

module execute (
    input  logic                 clk,
    input  logic                 arst_n,
    input  isa_pkg::opcode_e     dx_op,
    input  isa_pkg::reg_idx_t    dx_rd,
    input  isa_pkg::data_t       dx_a,
    input  isa_pkg::data_t       dx_b,
    input  isa_pkg::data_t       dx_imm,
    input  logic                 dx_we,
    input  logic                 dx_load,
    input  logic                 dx_halt,
    input  hazard_pkg::fwd_sel_e fwd_a,
    input  hazard_pkg::fwd_sel_e fwd_b,
    input  isa_pkg::data_t       mem_alu_result,
    input  isa_pkg::data_t       wb_data,
    output isa_pkg::data_t       xm_result,
    output isa_pkg::data_t       xm_store_data,
    output isa_pkg::reg_idx_t    xm_rd,
    output logic                 xm_we,
    output logic                 xm_load,
    output logic                 xm_store,
    output logic                 xm_halt
);
    import isa_pkg::*;
    import hazard_pkg::*;

    data_t op_a;
    data_t op_b;
    data_t result;

    function automatic data_t fwd_mux(fwd_sel_e sel, data_t reg_val, data_t mem_val,
                                      data_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, dx_a, mem_alu_result, wb_data);
    assign op_b = fwd_mux(fwd_b, dx_b, mem_alu_result, wb_data);   // Also the store data

    always_comb begin
        case (dx_op)
            OP_ADD:       result = op_a + op_b;
            OP_SUB:       result = op_a - op_b;
            OP_AND:       result = op_a & op_b;
            OP_XOR:       result = op_a ^ op_b;
            OP_LLI:       result = dx_imm;
            OP_LW, OP_SW: result = op_a + dx_imm;      // Base plus offset
            default:      result = '0;
        endcase
    end

    // XM register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xm_rd    <= '0;
            xm_we    <= 1'b0;
            xm_load  <= 1'b0;
            xm_store <= 1'b0;
            xm_halt  <= 1'b0;
        end else begin
            xm_rd    <= dx_rd;
            xm_we    <= dx_we;
            xm_load  <= dx_load;
            xm_store <= (dx_op == OP_SW);
            xm_halt  <= dx_halt;
        end
    end

    always_ff @(posedge clk) begin
        xm_result     <= result;
        xm_store_data <= op_b;
    end

endmodule

/* design/decode.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module decode (
    input  logic                clk,
    input  logic                arst_n,
    input  isa_pkg::data_t      fd_instr,
    input  isa_pkg::data_t      fd_pc_plus2,
    input  logic                stall_fd,
    input  hazard_pkg::br_fwd_e fwd_br,
    input  isa_pkg::data_t      mem_alu_result,
    input  logic                wb_valid,
    input  isa_pkg::reg_idx_t   wb_reg,
    input  isa_pkg::data_t      wb_data,
    output logic                flush,
    output isa_pkg::data_t      branch_target,
    output logic                halt_seen,
    output isa_pkg::reg_idx_t   rs_d,
    output isa_pkg::reg_idx_t   rt_d,
    output logic                is_branch_d,
    output logic                is_store_d,
    output isa_pkg::opcode_e    dx_op,
    output isa_pkg::reg_idx_t   dx_rd,
    output isa_pkg::reg_idx_t   dx_rs,
    output isa_pkg::reg_idx_t   dx_rt,
    output isa_pkg::data_t      dx_a,
    output isa_pkg::data_t      dx_b,
    output isa_pkg::data_t      dx_imm,
    output logic                dx_we,
    output logic                dx_load,
    output logic                dx_halt
);
    import isa_pkg::*;
    import hazard_pkg::*;

    data_t   rf [`REG_COUNT];
    instr_u  ins;
    opcode_e op;
    data_t   src_a;
    data_t   src_b;
    data_t   br_val;
    logic    is_rr;
    logic    is_lli;
    logic    is_load;
    logic    is_hlt;
    logic    writes;
    logic    halted;

    // Register read with same-cycle writeback visible
    function automatic data_t rf_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_valid && (wb_reg == idx)) begin
            return wb_data;
        end
        return rf[idx];
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////

    assign ins         = fd_instr;
    assign op          = ins.r.op;
    assign is_rr       = op inside {OP_ADD, OP_SUB, OP_AND, OP_XOR};
    assign is_lli      = (op == OP_LLI);
    assign is_load     = (op == OP_LW);
    assign is_store_d  = (op == OP_SW);
    assign is_branch_d = (op == OP_BEQZ);
    assign is_hlt      = (op == OP_HLT);
    assign writes      = (is_rr || is_lli || is_load) && (ins.r.rd != '0);   // r0 stays zero

    // Zero unless the field is a real source
    assign rs_d = is_branch_d ? ins.i.rd :
                  (is_rr || is_load || is_store_d) ? ins.r.rs : '0;
    assign rt_d = is_store_d ? ins.r.rd : (is_rr ? ins.r.rt : '0);   // Store data sits in rd

    always_comb begin
        src_a = rf_read(rs_d);
        src_b = rf_read(rt_d);
    end

    // BEQZ resolved here
    assign br_val        = (fwd_br == BR_MEM) ? mem_alu_result : src_a;
    assign branch_target = fd_pc_plus2 + (data_t'(signed'(ins.i.imm8)) << 1);
    assign flush         = is_branch_d && (br_val == '0) && !stall_fd;   // Source must be settled
    assign halt_seen     = halted || is_hlt;

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            rf[wb_reg] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (is_hlt) begin
            halted <= 1'b1;                    // Sticky until reset
        end
    end

    ////////////////////////////////////////////////////////////////////
    // DX register
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dx_op   <= OP_ADD;
            dx_rd   <= '0;
            dx_rs   <= '0;
            dx_rt   <= '0;
            dx_we   <= 1'b0;
            dx_load <= 1'b0;
            dx_halt <= 1'b0;
        end else if (stall_fd) begin
            dx_op   <= OP_ADD;                 // Bubble
            dx_rd   <= '0;
            dx_rs   <= '0;
            dx_rt   <= '0;
            dx_we   <= 1'b0;
            dx_load <= 1'b0;
            dx_halt <= 1'b0;
        end else begin
            dx_op   <= op;
            dx_rd   <= ins.r.rd;
            dx_rs   <= rs_d;
            dx_rt   <= rt_d;
            dx_we   <= writes;
            dx_load <= is_load;
            dx_halt <= is_hlt;
        end
    end

    always_ff @(posedge clk) begin
        dx_a   <= src_a;
        dx_b   <= src_b;
        dx_imm <= is_lli ? data_t'(signed'(ins.i.imm8)) : data_t'(ins.r.rt);  // LW/SW offset
    end

    // A branch waiting on its source must not redirect fetch
    assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> !(dx_we && (dx_rd == rs_d)))
        else $error("Flush raised while the branch source is still in execute");

endmodule

/* design/fetch.sv */
`timescale 1ns/100ps
`include "cpu_config.svh"

module fetch (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           stall_fd,
    input  logic                           flush,
    input  logic                           halt_seen,
    input  isa_pkg::data_t                 branch_target,
    input  logic                           prog_we,
    input  logic [$clog2(`IMEM_DEPTH)-1:0] prog_addr,
    input  isa_pkg::data_t                 prog_data,
    output isa_pkg::data_t                 pc,
    output isa_pkg::data_t                 fd_instr,
    output isa_pkg::data_t                 fd_pc_plus2
);
    import isa_pkg::*;

    localparam int IA_W = $clog2(`IMEM_DEPTH);

    data_t imem [`IMEM_DEPTH];    // Program words
    data_t pc_plus2;
    data_t instr;

    assign pc_plus2 = pc + 16'd2;              // Byte addressed PC
    assign instr    = imem[pc[IA_W:1]];        // Word index from PC

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;      // Load port
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (flush) begin
            pc <= branch_target;               // Taken branch from decode
        end else if (!stall_fd && !halt_seen) begin
            pc <= pc_plus2;                    // Frozen once HLT decoded
        end
    end

    // FD register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd_instr    <= NOP_INSTR;
            fd_pc_plus2 <= '0;
        end else if (flush || halt_seen) begin
            fd_instr    <= NOP_INSTR;          // Kill wrong-path or post-halt word
        end else if (!stall_fd) begin
            fd_instr    <= instr;
            fd_pc_plus2 <= pc_plus2;
        end
    end

endmodule

/* design/hazard_pkg.sv */
package hazard_pkg;

    // Execute operand source
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,   // Value read in decode
        FWD_MEM = 2'b01,   // ALU result in memory stage
        FWD_WB  = 2'b10    // Writeback data
    } fwd_sel_e;

    // Branch source in decode
    typedef enum logic {
        BR_REG = 1'b0,     // Register file with write bypass
        BR_MEM = 1'b1      // ALU result in memory stage
    } br_fwd_e;

endpackage

/* design/isa_pkg.sv */
`include "cpu_config.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0]            data_t;
    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,   // rd = rs + rt
        OP_SUB  = 4'h1,   // rd = rs - rt
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_LLI  = 4'h4,   // rd = sext(imm8)
        OP_LW   = 4'h5,   // rd = mem[rs + off]
        OP_SW   = 4'h6,   // mem[rs + off] = rd
        OP_BEQZ = 4'h7,   // Taken when rd is zero
        OP_HLT  = 4'hf
    } opcode_e;

    // Register view with rt as the offset for LW and SW
    typedef struct packed {
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
    } instr_r_t;

    // Immediate view for LLI and BEQZ
    typedef struct packed {
        opcode_e    op;
        reg_idx_t   rd;
        logic [7:0] imm8;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    localparam data_t NOP_INSTR = '0;   // ADD r0, r0, r0

endpackage

/* design/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and instruction word width
`define DATA_W      16

// Architectural registers
`define REG_COUNT   16

// Words in each memory
`define IMEM_DEPTH  256
`define DMEM_DEPTH  256

`endif
